// ==== hw/cpu_cfg.svh ====
// CPU front end configuration
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data and instruction word width
`define CPU_XLEN 16

// Instruction memory words, must be a power of two
`define CPU_IMEM_DEPTH 256

// Architectural register count
`define CPU_NREGS 16

// Opcode F, all fields zero
`define CPU_NOP_WORD 16'hF000

`endif

// ==== hw/cpu_pkg.sv ====
// CPU front end types
`include "cpu_cfg.svh"

package cpu_pkg;

   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_ADDI = 4'h4, // Imm sits in rt field
      OP_LOAD = 4'h8,
      OP_SAVE = 4'h9,
      OP_CALL = 4'hC,
      OP_NOP  = 4'hF  // Unlisted codes also land here
   } opcode_e;

   // ALU and addi form
   typedef struct packed {
      opcode_e    op;
      logic [3:0] rd;
      logic [3:0] rs;
      logic [3:0] rt;
   } instr_reg_t;

   // Load and save form
   typedef struct packed {
      opcode_e    op;
      logic [3:0] rd;
      logic [7:0] imm8;
   } instr_mem_t;

   // Call form, absolute target
   typedef struct packed {
      opcode_e     op;
      logic [11:0] target12;
   } instr_call_t;

   typedef union packed {
      instr_reg_t  r;
      instr_mem_t  m;
      instr_call_t c;
   } instr_u;

   // IF/ID register content
   typedef struct packed {
      instr_u                instr;
      logic [`CPU_XLEN-1:0] pc;
   } if_id_t;

   typedef struct packed {
      logic                 valid;
      logic [`CPU_XLEN-1:0] target;
   } redirect_t;

   // Decoded bundle out of ID
   typedef struct packed {
      logic                 valid;
      logic [`CPU_XLEN-1:0] pc;
      opcode_e              opcode;
      logic [3:0]           rd;
      logic [`CPU_XLEN-1:0] rs_val;
      logic [`CPU_XLEN-1:0] rt_val;
      logic [`CPU_XLEN-1:0] imm;
      logic                 reg_write;
      logic                 mem_read;
      logic                 mem_write;
      logic                 use_imm;
   } id_out_t;

   // Program load port
   typedef struct packed {
      logic                              en;
      logic [$clog2(`CPU_IMEM_DEPTH)-1:0] addr;
      logic [`CPU_XLEN-1:0]              data;
   } imem_wr_t;

   // Register file write port
   typedef struct packed {
      logic                 en;
      logic [3:0]           addr;
      logic [`CPU_XLEN-1:0] data;
   } rf_wr_t;

endpackage

// ==== hw/fetch_stage.sv ====
// Instruction fetch stage
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch_stage (
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  logic               hazard,
   input  cpu_pkg::redirect_t redirect,
   input  cpu_pkg::imem_wr_t  imem_wr,
   output cpu_pkg::if_id_t    if_word
);

   localparam int AW = $clog2(`CPU_IMEM_DEPTH);

   logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH]; // Program store
   logic [`CPU_XLEN-1:0] pc;
   logic [`CPU_XLEN-1:0] pc_nxt;
   logic [`CPU_XLEN-1:0] issued_pc;             // pc handed to IF/ID last edge

   // Program load, open at any time
   always_ff @(posedge clk) begin
      if (imem_wr.en) begin
         imem[imem_wr.addr] <= imem_wr.data;
      end
   end

   // Next pc priority: idle, call, replay, step
   always_comb begin
      if (!run) begin
         pc_nxt = '0;                         // Parked at reset vector
      end else if (redirect.valid) begin
         pc_nxt = redirect.target;            // Call target from ID
      end else if (hazard) begin
         // Word in IF/ID gets squashed, fetch it again
         pc_nxt = issued_pc;
      end else begin
         pc_nxt = pc + `CPU_XLEN'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc        <= '0;
         issued_pc <= '0;
      end else begin
         pc        <= pc_nxt;
         issued_pc <= pc;                     // Tracks what IF/ID saw
      end
   end

   // Async read off registered pc
   always_comb begin
      if_word.pc = pc;
      if (run) begin
         if_word.instr = imem[pc[AW-1:0]];
      end else begin
         if_word.instr = `CPU_NOP_WORD;       // Idle feeds bubbles
      end
   end

endmodule

// ==== hw/ifid_reg.sv ====
// IF/ID pipeline register
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module ifid_reg (
   input  logic               clk,
   input  logic               rst,
   input  logic               hazard,
   input  cpu_pkg::redirect_t redirect,
   input  cpu_pkg::if_id_t    if_word,
   output cpu_pkg::if_id_t    ifid
);

   logic squash; // Drop the incoming word

   // Load-use stall or taken call
   assign squash = hazard || redirect.valid;

   always_ff @(posedge clk) begin
      if (rst) begin
         ifid.instr <= `CPU_NOP_WORD;
         ifid.pc    <= '0;
      end else if (squash) begin
         ifid.instr <= `CPU_NOP_WORD;  // Bubble into ID
         ifid.pc    <= ifid.pc;        // pc holds a real value
      end else begin
         ifid <= if_word;
      end
   end

endmodule

// ==== hw/decode_stage.sv ====
// Instruction decode stage
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decode_stage (
   input  logic               clk,
   input  logic               rst,
   input  cpu_pkg::if_id_t    ifid,
   input  cpu_pkg::rf_wr_t    rf_wr,
   output logic               hazard,
   output cpu_pkg::redirect_t redirect,
   output cpu_pkg::id_out_t   id_out
);

   // Empty slot, nothing enabled
   localparam cpu_pkg::id_out_t BUBBLE = '{
      opcode  : cpu_pkg::OP_NOP,
      default : '0
   };

   logic [`CPU_XLEN-1:0] rf [`CPU_NREGS]; // Architectural registers
   cpu_pkg::instr_u      ins;
   cpu_pkg::opcode_e     op;              // Cleaned opcode
   cpu_pkg::id_out_t     dec;
   logic [3:0]           rt_addr;
   logic                 reads_rs;
   logic                 reads_rt;
   logic                 reads_rd;

   assign ins = ifid.instr;

   // Write lands at the edge, same-cycle read sees old data
   always_ff @(posedge clk) begin
      if (rf_wr.en) begin
         rf[rf_wr.addr] <= rf_wr.data;
      end
   end

   // Fold reserved codes onto nop
   always_comb begin
      case (ins.r.op)
         cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
         cpu_pkg::OP_ADDI, cpu_pkg::OP_LOAD, cpu_pkg::OP_SAVE,
         cpu_pkg::OP_CALL: op = ins.r.op;
         default:          op = cpu_pkg::OP_NOP;
      endcase
   end

   // Which source fields this word really reads
   always_comb begin
      reads_rs = 1'b0;
      reads_rt = 1'b0;
      reads_rd = 1'b0;
      case (op)
         cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR: begin
            reads_rs = 1'b1;
            reads_rt = 1'b1;
         end
         cpu_pkg::OP_ADDI: reads_rs = 1'b1;
         cpu_pkg::OP_SAVE: reads_rd = 1'b1;   // Store data comes from rd
         default:          ;
      endcase
   end

   // Second read port serves rd for save
   assign rt_addr = reads_rd ? ins.m.rd : ins.r.rt;

   // Load in ID output feeding a reader in IF/ID
   assign hazard = id_out.valid && id_out.mem_read &&
                   ((reads_rs && (id_out.rd == ins.r.rs)) ||
                    (reads_rt && (id_out.rd == ins.r.rt)) ||
                    (reads_rd && (id_out.rd == ins.m.rd)));

   // Call resolves here, zero-extended
   assign redirect.valid  = (op == cpu_pkg::OP_CALL);
   assign redirect.target = `CPU_XLEN'(ins.c.target12);

   always_comb begin
      dec        = BUBBLE;
      dec.valid  = (op != cpu_pkg::OP_NOP);
      dec.pc     = ifid.pc;
      dec.opcode = op;
      dec.rd     = ins.r.rd;
      dec.rs_val = rf[ins.r.rs];
      dec.rt_val = rf[rt_addr];
      case (op)
         cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR:
            dec.reg_write = 1'b1;
         cpu_pkg::OP_ADDI: begin
            dec.imm       = `CPU_XLEN'(ins.r.rt); // 4-bit imm
            dec.reg_write = 1'b1;
            dec.use_imm   = 1'b1;
         end
         cpu_pkg::OP_LOAD: begin
            dec.imm       = `CPU_XLEN'(ins.m.imm8);
            dec.reg_write = 1'b1;
            dec.mem_read  = 1'b1;
            dec.use_imm   = 1'b1;
         end
         cpu_pkg::OP_SAVE: begin
            dec.imm       = `CPU_XLEN'(ins.m.imm8);
            dec.mem_write = 1'b1;
            dec.use_imm   = 1'b1;
         end
         cpu_pkg::OP_CALL: dec.imm = `CPU_XLEN'(ins.c.target12);
         default:          ;
      endcase
   end

   // Stalled word is dropped here, fetch replays it
   always_ff @(posedge clk) begin
      if (rst || hazard) begin
         id_out <= BUBBLE;
      end else begin
         id_out <= dec;
      end
   end

endmodule

// ==== hw/cpu_front.sv ====
// CPU front end top
`timescale 1ns/1ps

module cpu_front (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  cpu_pkg::imem_wr_t imem_wr,
   input  cpu_pkg::rf_wr_t   rf_wr,
   output cpu_pkg::id_out_t  id_out
);

   cpu_pkg::if_id_t    if_word;  // Fetch to IF/ID
   cpu_pkg::if_id_t    ifid;     // IF/ID to decode
   logic               hazard;   // Load-use stall level
   cpu_pkg::redirect_t redirect; // Call from decode

   fetch_stage u_fetch (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .hazard   (hazard),
      .redirect (redirect),
      .imem_wr  (imem_wr),
      .if_word  (if_word)
   );

   ifid_reg u_ifid (
      .clk      (clk),
      .rst      (rst),
      .hazard   (hazard),
      .redirect (redirect),
      .if_word  (if_word),
      .ifid     (ifid)
   );

   decode_stage u_decode (
      .clk      (clk),
      .rst      (rst),
      .ifid     (ifid),
      .rf_wr    (rf_wr),
      .hazard   (hazard),
      .redirect (redirect),
      .id_out   (id_out)
   );

endmodule

// ==== dv/cpu_front_assert.sv ====
// CPU front end assertions
`timescale 1ns/1ps

module cpu_front_assert (
   input logic               clk,
   input logic               rst,
   input logic               run,
   input logic               hazard,
   input cpu_pkg::redirect_t redirect,
   input cpu_pkg::if_id_t    ifid,
   input cpu_pkg::id_out_t   id_out
);

   int fail_cnt = 0; // Failed assertion tally

   // True when word w reads register r as a source
   function automatic logic reads_reg(input logic [15:0] w, input logic [3:0] r);
      case (w[15:12])
         4'h0, 4'h1, 4'h2, 4'h3: return (w[7:4] == r) || (w[3:0] == r); // rs and rt
         4'h4:                   return w[7:4] == r;                    // addi rs
         4'h9:                   return w[11:8] == r;                   // Save data
         default:                return 1'b0;
      endcase
   endfunction

   // Nothing leaves ID before the first fetched word has crossed IF/ID
   a_idle_ctl: assert property (@(posedge clk) disable iff (rst)
      !$past(run) |-> !hazard && !redirect.valid && !id_out.valid)
      else begin
         fail_cnt++;
         $error("Control active before run settled");
      end

   a_idle_out: assert property (@(posedge clk) disable iff (rst)
      !$past(run, 2) |-> !id_out.valid)
      else begin
         fail_cnt++;
         $error("Valid output too early after run");
      end

   // Stall exactly when a valid load feeds a reader in IF/ID
   a_haz_pair: assert property (@(posedge clk) disable iff (rst)
      hazard == (id_out.valid && id_out.opcode == cpu_pkg::OP_LOAD &&
                 reads_reg(ifid.instr, id_out.rd)))
      else begin
         fail_cnt++;
         $error("Hazard does not match a load-use pair");
      end

   a_haz_once: assert property (@(posedge clk) disable iff (rst)
      hazard |=> !hazard)
      else begin
         fail_cnt++;
         $error("Hazard held longer than one cycle");
      end

   // Two bubbles, then the reader with its own pc
   a_haz_bubble: assert property (@(posedge clk) disable iff (rst)
      $past(hazard) || $past(hazard, 2) |-> !id_out.valid)
      else begin
         fail_cnt++;
         $error("Missing bubble after load-use stall");
      end

   a_haz_replay: assert property (@(posedge clk) disable iff (rst)
      $past(hazard, 3) |-> id_out.valid && id_out.pc == $past(ifid.pc, 3) &&
                           id_out.pc == $past(id_out.pc, 3) + 16'd1)
      else begin
         fail_cnt++;
         $error("Stalled reader lost or misplaced");
      end

   // Call shows up next cycle, one bubble, then the target
   a_call_out: assert property (@(posedge clk) disable iff (rst)
      $past(redirect.valid) |-> id_out.valid && id_out.opcode == cpu_pkg::OP_CALL)
      else begin
         fail_cnt++;
         $error("Call not registered at ID output");
      end

   a_call_bubble: assert property (@(posedge clk) disable iff (rst)
      $past(redirect.valid, 2) |-> !id_out.valid)
      else begin
         fail_cnt++;
         $error("Word after call was not squashed");
      end

   a_call_target: assert property (@(posedge clk) disable iff (rst)
      $past(redirect.valid, 3) |->
         id_out.valid && id_out.pc == {4'h0, $past(ifid.instr.c.target12, 3)})
      else begin
         fail_cnt++;
         $error("Call target did not follow the call");
      end

   // Straight-line flow steps by one
   a_step: assert property (@(posedge clk) disable iff (rst)
      id_out.valid && $past(id_out.valid) && $past(id_out.opcode) != cpu_pkg::OP_CALL
      |-> id_out.pc == $past(id_out.pc) + 16'd1)
      else begin
         fail_cnt++;
         $error("Consecutive pcs do not step by one");
      end

endmodule

bind cpu_front cpu_front_assert u_assert (
   .clk      (clk),
   .rst      (rst),
   .run      (run),
   .hazard   (hazard),
   .redirect (redirect),
   .ifid     (ifid),
   .id_out   (id_out)
);

// ==== dv/cpu_front_tb.sv ====
// CPU front end testbench
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_front_tb;

   localparam int PROG_LEN    = 20;
   localparam int SEQ_LEN     = 18;                // Valid pcs expected at id_out
   localparam int CYCLE_LIMIT = PROG_LEN * 4 + 50;

   logic              clk = 1'b0;
   logic              rst;
   logic              run;
   cpu_pkg::imem_wr_t imem_wr;
   cpu_pkg::rf_wr_t   rf_wr;
   cpu_pkg::id_out_t  id_out;

   logic [`CPU_XLEN-1:0] prog_copy [PROG_LEN];      // Program as written
   logic [`CPU_XLEN-1:0] rf_copy   [`CPU_NREGS];    // Register values as written
   logic [`CPU_XLEN-1:0] exp_pcs   [SEQ_LEN];       // Issue order through stalls and call
   logic [31:0]          rng = 32'd18;
   logic [4:0]           seq_idx = 5'd0;
   logic [4:0]           i;
   int                   err_cnt = 0;
   int                   assert_fails;
   int                   cycles = 0;

   cpu_front u_cpu_front (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .imem_wr (imem_wr),
      .rf_wr   (rf_wr),
      .id_out  (id_out)
   );

   always #2 clk = ~clk; // 4 ns period

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic set_register(input logic [3:0] addr, input logic [15:0] data);
      rf_wr.en      = 1'b1;
      rf_wr.addr    = addr;
      rf_wr.data    = data;
      rf_copy[addr] = data;
      @(negedge clk);
      rf_wr.en = 1'b0;
   endtask

   task automatic store_word(input logic [7:0] addr, input logic [15:0] data);
      imem_wr.en   = 1'b1;
      imem_wr.addr = addr;
      imem_wr.data = data;
      @(negedge clk);
      imem_wr.en = 1'b0;
   endtask

   task automatic load_program();
      logic [4:0] a;
      prog_copy[0]  = 16'h0123; // add  r1, r2, r3
      prog_copy[1]  = 16'h1456; // sub  r4, r5, r6
      prog_copy[2]  = 16'h4785; // addi r7, r8, 5
      prog_copy[3]  = 16'h893C; // load r9
      prog_copy[4]  = 16'h0A91; // add reads r9 as rs
      prog_copy[5]  = 16'h2BCD; // and  r11, r12, r13
      prog_copy[6]  = 16'h827F; // load r2
      prog_copy[7]  = 16'h3342; // or reads r2 as rt
      prog_copy[8]  = 16'h8511; // load r5, right behind a stall
      prog_copy[9]  = 16'h465A; // addi reads r5
      prog_copy[10] = 16'h8EA5; // load r14
      prog_copy[11] = 16'h9E20; // save r14
      prog_copy[12] = 16'hC010; // call 16
      prog_copy[13] = 16'h0111; // Skipped by call
      prog_copy[14] = 16'h1222;
      prog_copy[15] = 16'h3333;
      prog_copy[16] = 16'h9344; // save r3 behind call, no stall
      prog_copy[17] = 16'h8001; // load r0
      prog_copy[18] = 16'h2876; // and, no r0 read
      prog_copy[19] = 16'hC013; // Self call parks fetch
      for (a = 5'd0; a < 5'(PROG_LEN); a++) begin
         store_word({3'b000, a}, prog_copy[a]);
      end
   endtask

   task automatic compare_field(input string what, input logic [15:0] pc,
                                input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp) else begin
         $display("Fail %0t: %s at pc %0d is %h, expected %h", $time, what, pc, got, exp);
         err_cnt++;
      end
   endtask

   // Expected fields straight from the encoding rules
   task automatic check_bundle(input cpu_pkg::id_out_t o);
      logic [15:0] w;
      logic [3:0]  exp_ctl;  // reg_write, mem_read, mem_write, use_imm
      logic [15:0] exp_imm;
      logic        has_imm;
      logic        uses_rs;
      logic        uses_rt;
      logic        uses_rd;  // Save data
      w       = prog_copy[o.pc[4:0]];
      exp_ctl = 4'b0000;
      exp_imm = 16'h0000;
      has_imm = 1'b0;
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      uses_rd = 1'b0;
      case (w[15:12])
         4'h0, 4'h1, 4'h2, 4'h3: begin
            exp_ctl = 4'b1000;
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         4'h4: begin
            exp_ctl = 4'b1001;
            exp_imm = {12'h000, w[3:0]};
            has_imm = 1'b1;
            uses_rs = 1'b1;
         end
         4'h8: begin
            exp_ctl = 4'b1101;
            exp_imm = {8'h00, w[7:0]};
            has_imm = 1'b1;
         end
         4'h9: begin
            exp_ctl = 4'b0011;
            exp_imm = {8'h00, w[7:0]};
            has_imm = 1'b1;
            uses_rd = 1'b1;
         end
         default: ; // Call drives no controls
      endcase
      compare_field("opcode", o.pc, {12'h000, o.opcode}, {12'h000, w[15:12]});
      compare_field("controls", o.pc,
                    {12'h000, o.reg_write, o.mem_read, o.mem_write, o.use_imm},
                    {12'h000, exp_ctl});
      if (w[15:12] != 4'hC) compare_field("rd", o.pc, {12'h000, o.rd}, {12'h000, w[11:8]});
      if (has_imm) compare_field("imm", o.pc, o.imm, exp_imm);
      if (uses_rs) compare_field("rs_val", o.pc, o.rs_val, rf_copy[w[7:4]]);
      if (uses_rt) compare_field("rt_val", o.pc, o.rt_val, rf_copy[w[3:0]]);
      if (uses_rd) compare_field("rt_val", o.pc, o.rt_val, rf_copy[w[11:8]]);
   endtask

   // id_out is stable at the falling edge
   always @(negedge clk) begin
      if (id_out.valid === 1'b1 && seq_idx < 5'(SEQ_LEN)) begin
         compare_field("pc order", id_out.pc, id_out.pc, exp_pcs[seq_idx]);
         if (int'(id_out.pc) < PROG_LEN) begin
            check_bundle(id_out);
         end
         seq_idx <= seq_idx + 5'd1;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, %0d of %0d instructions seen",
                  cycles, seq_idx, SEQ_LEN);
         $display("Errors: %0d checks, %0d assertions", err_cnt,
                  u_cpu_front.u_assert.fail_cnt);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      rst     = 1'b1;
      run     = 1'b0;
      imem_wr = '0;
      rf_wr   = '0;
      for (i = 5'd0; i < 5'd13; i++) begin
         exp_pcs[i] = {11'h000, i};    // Straight run up to the call
      end
      exp_pcs[13] = 16'd16;
      exp_pcs[14] = 16'd17;
      exp_pcs[15] = 16'd18;
      exp_pcs[16] = 16'd19;
      exp_pcs[17] = 16'd19;            // Self call comes back once
      repeat (3) @(negedge clk);
      rst = 1'b0;
      for (i = 5'd0; i < 5'd16; i++) begin
         rng = xorshift(rng);
         set_register(i[3:0], rng[15:0]);
      end
      load_program();
      run = 1'b1;
      wait (seq_idx == 5'(SEQ_LEN));
      repeat (4) @(negedge clk);       // Let trailing assertions sample
      assert_fails = u_cpu_front.u_assert.fail_cnt;
      $display("Errors: %0d checks, %0d assertions", err_cnt, assert_fails);
      if (err_cnt == 0 && assert_fails == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/ifid_reg.sv
hw/decode_stage.sv
hw/cpu_front.sv
dv/cpu_front_assert.sv
dv/cpu_front_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CPU front end testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert --no-stop-fail \
   -f project.f \
   --top-module cpu_front_tb \
   -Mdir "$BUILD_DIR" -o sim

"./$BUILD_DIR/sim" | tee "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
